// ==== design/friscv_io_pkg.sv ====
//////////////////////////////////////////////////
// IO read path package with AXI field types,
// response codes and IO window reset values
//////////////////////////////////////////////////

`default_nettype none

package friscv_io_pkg;

    // Bus widths
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_ID_W   = 8;
    localparam int AXI_PROT_W = 3;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_RESP_W = 2;

    // AXI field types
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_ID_W-1:0]   axi_id_t;
    typedef logic [AXI_PROT_W-1:0] axi_prot_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [AXI_RESP_W-1:0] axi_resp_t;

    // Read response codes
    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_DECERR = 2'd3;

    // IO window after reset
    localparam axi_addr_t IO_BASE_RST  = 32'h1000_0000;
    localparam axi_addr_t IO_LIMIT_RST = 32'h1000_FFFF;

    // Target of a configuration write
    typedef enum logic {SEL_BASE, SEL_LIMIT} cfg_sel_t;

    // Error responder states
    typedef enum logic {ERR_IDLE, ERR_PEND} err_state_t;

endpackage

`default_nettype wire

// ==== design/friscv_axi_ar_if.sv ====
//////////////////////////////////////////////////
// AXI read address channel bundle
//////////////////////////////////////////////////

`default_nettype none

interface friscv_axi_ar_if;

    import friscv_io_pkg::*;

    // Handshake
    logic      arvalid;
    logic      arready;

    // Payload, stable while arvalid waits for arready
    axi_addr_t araddr;
    axi_prot_t arprot;
    axi_id_t   arid;

    // Issuer side
    modport master (
        output arvalid, araddr, arprot, arid,
        input  arready
    );

    // Receiver side
    modport slave (
        input  arvalid, araddr, arprot, arid,
        output arready
    );

endinterface

`default_nettype wire

// ==== design/friscv_scfifo.sv ====
//////////////////////////////////////////////////
// Single clock FIFO with the head entry shown
// on data_out and full/empty flags
//////////////////////////////////////////////////

`default_nettype none

module friscv_scfifo #(
    // Number of entries, a power of two of at least 2
    parameter int DEPTH  = 4,
    // Word width
    parameter int DATA_W = 8
) (
    input  wire               aclk,
    input  wire               rst_n,
    input  wire  [DATA_W-1:0] data_in,
    input  wire               push,
    output logic              full,
    output logic [DATA_W-1:0] data_out,
    input  wire               pull,
    output logic              empty
);

    //////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] CNT_FULL = (PTR_W + 1)'(DEPTH);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    // One extra bit to tell full from empty
    logic [PTR_W:0]    count;

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pull)
                rd_ptr <= rd_ptr + 1'b1;
            // Occupancy only moves on a lone push or lone pull
            case ({push, pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Write port
    always_ff @(posedge aclk) begin
        if (push)
            mem[wr_ptr] <= data_in;
    end

    // Head entry
    assign data_out = mem[rd_ptr];
    assign full     = (count == CNT_FULL);
    assign empty    = (count == '0);

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_no_overflow: assert property (@(posedge aclk) disable iff (!rst_n) full |-> !push)
        else $error("FIFO push while full");

    a_no_underflow: assert property (@(posedge aclk) disable iff (!rst_n) empty |-> !pull)
        else $error("FIFO pull while empty");

endmodule

`default_nettype wire

// ==== design/friscv_cache_io_fetcher.sv ====
//////////////////////////////////////////////////
// IO fetcher buffering outstanding read address
// requests from the control unit
//////////////////////////////////////////////////

`default_nettype none

module friscv_cache_io_fetcher #(
    // Outstanding requests held before back-pressure
    parameter int OSTDREQ_NUM = 4
) (
    input  wire                        aclk,
    input  wire                        rst_n,
    // Control unit side
    input  wire                        mst_arvalid,
    output logic                       mst_arready,
    input  wire friscv_io_pkg::axi_addr_t mst_araddr,
    input  wire friscv_io_pkg::axi_prot_t mst_arprot,
    input  wire friscv_io_pkg::axi_id_t   mst_arid,
    // Toward the router
    friscv_axi_ar_if.master            out_ar
);

    import friscv_io_pkg::*;

    // Protection, ID and address in one word
    localparam int WORD_W = $bits(axi_prot_t) + $bits(axi_id_t) + $bits(axi_addr_t);

    logic              fifo_full;
    logic              fifo_empty;
    logic              fifo_push;
    logic              fifo_pull;
    logic [WORD_W-1:0] fifo_wdata;
    logic [WORD_W-1:0] fifo_rdata;

    // Push on accepted request, pull on completed transfer
    assign fifo_wdata = {mst_arprot, mst_arid, mst_araddr};
    assign fifo_push  = mst_arvalid && mst_arready;
    assign fifo_pull  = out_ar.arvalid && out_ar.arready;

    friscv_scfifo #(
        .DEPTH  (OSTDREQ_NUM),
        .DATA_W (WORD_W)
    ) req_fifo (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .data_in  (fifo_wdata),
        .push     (fifo_push),
        .full     (fifo_full),
        .data_out (fifo_rdata),
        .pull     (fifo_pull),
        .empty    (fifo_empty)
    );

    // Flags drive the handshakes
    assign mst_arready    = !fifo_full;
    assign out_ar.arvalid = !fifo_empty;
    assign {out_ar.arprot, out_ar.arid, out_ar.araddr} = fifo_rdata;

endmodule

`default_nettype wire

// ==== design/friscv_io_range_regs.sv ====
//////////////////////////////////////////////////
// IO window registers set by a one cycle
// configuration strobe
//////////////////////////////////////////////////

`default_nettype none

module friscv_io_range_regs (
    input  wire                           aclk,
    input  wire                           rst_n,
    // Configuration strobe, no back-pressure
    input  wire                           cfg_wr,
    input  wire friscv_io_pkg::cfg_sel_t  cfg_sel,
    input  wire friscv_io_pkg::axi_addr_t cfg_wdata,
    // Current window, both bounds inclusive
    output friscv_io_pkg::axi_addr_t      io_base,
    output friscv_io_pkg::axi_addr_t      io_limit
);

    import friscv_io_pkg::*;

    //////////////////////////////////////////////////
    // Window registers
    //////////////////////////////////////////////////

    // New value visible to the router from next cycle
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            io_base  <= IO_BASE_RST;
            io_limit <= IO_LIMIT_RST;
        end else if (cfg_wr) begin
            // Only the selected bound moves
            case (cfg_sel)
                SEL_BASE:  io_base  <= cfg_wdata;
                SEL_LIMIT: io_limit <= cfg_wdata;
                default:   io_base  <= io_base;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // A strobe must name a register
    a_sel_known: assert property (
        @(posedge aclk) disable iff (!rst_n)
        cfg_wr |-> !$isunknown(cfg_sel)
    ) else $error("Config write with unknown select");

endmodule

`default_nettype wire

// ==== design/friscv_io_read_router.sv ====
//////////////////////////////////////////////////
// IO read router steering requests to memory or
// to a decode error responder, merging responses
//////////////////////////////////////////////////

`default_nettype none

module friscv_io_read_router (
    input  wire                           aclk,
    input  wire                           rst_n,
    // Buffered requests and memory side
    friscv_axi_ar_if.slave                req_ar,
    friscv_axi_ar_if.master               mem_ar,
    // IO window
    input  wire friscv_io_pkg::axi_addr_t io_base,
    input  wire friscv_io_pkg::axi_addr_t io_limit,
    // Memory controller read data
    input  wire                           memctrl_rvalid,
    output logic                          memctrl_rready,
    input  wire friscv_io_pkg::axi_data_t memctrl_rdata,
    input  wire friscv_io_pkg::axi_resp_t memctrl_rresp,
    input  wire friscv_io_pkg::axi_id_t   memctrl_rid,
    // Master read data
    output logic                          mst_rvalid,
    input  wire                           mst_rready,
    output friscv_io_pkg::axi_data_t      mst_rdata,
    output friscv_io_pkg::axi_resp_t      mst_rresp,
    output friscv_io_pkg::axi_id_t        mst_rid
);

    import friscv_io_pkg::*;

    err_state_t err_state;
    axi_id_t    err_id;
    logic       in_range;
    logic       err_take;
    logic       err_ack;

    //////////////////////////////////////////////////
    // Address decode and steering
    //////////////////////////////////////////////////

    assign in_range = (req_ar.araddr >= io_base) && (req_ar.araddr <= io_limit);

    // In range goes straight through
    assign mem_ar.arvalid = req_ar.arvalid && in_range;
    assign mem_ar.araddr  = req_ar.araddr;
    assign mem_ar.arprot  = req_ar.arprot;
    assign mem_ar.arid    = req_ar.arid;

    // Out of range popped only by an idle responder
    assign req_ar.arready = in_range ? mem_ar.arready : (err_state == ERR_IDLE);
    assign err_take = req_ar.arvalid && !in_range && (err_state == ERR_IDLE);
    // Error reply consumed only when memory is silent
    assign err_ack  = (err_state == ERR_PEND) && !memctrl_rvalid && mst_rready;

    //////////////////////////////////////////////////
    // Decode error responder
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            err_state <= ERR_IDLE;
        end else begin
            case (err_state)
                ERR_IDLE: if (err_take) err_state <= ERR_PEND;
                ERR_PEND: if (err_ack)  err_state <= ERR_IDLE;
                default:  err_state <= ERR_IDLE;
            endcase
        end
    end

    // ID of the failed request
    always_ff @(posedge aclk) begin
        if (err_take)
            err_id <= req_ar.arid;
    end

    //////////////////////////////////////////////////
    // Response merge, memory first
    //////////////////////////////////////////////////

    assign memctrl_rready = mst_rready;
    assign mst_rvalid = memctrl_rvalid || (err_state == ERR_PEND);
    assign mst_rdata  = memctrl_rvalid ? memctrl_rdata : '0;
    assign mst_rresp  = memctrl_rvalid ? memctrl_rresp : RESP_DECERR;
    assign mst_rid    = memctrl_rvalid ? memctrl_rid   : err_id;

    // Stalled memory request holds still
    a_mem_ar_stable: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (mem_ar.arvalid && !mem_ar.arready) |=> (mem_ar.arvalid
            && $stable(mem_ar.araddr) && $stable(mem_ar.arprot) && $stable(mem_ar.arid))
    ) else $error("Memory read address changed before ready");

endmodule

`default_nettype wire

// ==== design/friscv_cache_io_top.sv ====
//////////////////////////////////////////////////
// IO read path top with fetcher, window registers
// and read router
//////////////////////////////////////////////////

`default_nettype none

module friscv_cache_io_top #(
    parameter int OSTDREQ_NUM = 4
) (
    input  wire                           aclk,
    input  wire                           rst_n,
    // Window configuration
    input  wire                           cfg_wr,
    input  wire friscv_io_pkg::cfg_sel_t  cfg_sel,
    input  wire friscv_io_pkg::axi_addr_t cfg_wdata,
    // Control unit read address
    input  wire                           mst_arvalid,
    output logic                          mst_arready,
    input  wire friscv_io_pkg::axi_addr_t mst_araddr,
    input  wire friscv_io_pkg::axi_prot_t mst_arprot,
    input  wire friscv_io_pkg::axi_id_t   mst_arid,
    // Memory controller read address
    output logic                          memctrl_arvalid,
    input  wire                           memctrl_arready,
    output friscv_io_pkg::axi_addr_t      memctrl_araddr,
    output friscv_io_pkg::axi_prot_t      memctrl_arprot,
    output friscv_io_pkg::axi_id_t        memctrl_arid,
    // Memory controller read data
    input  wire                           memctrl_rvalid,
    output logic                          memctrl_rready,
    input  wire friscv_io_pkg::axi_data_t memctrl_rdata,
    input  wire friscv_io_pkg::axi_resp_t memctrl_rresp,
    input  wire friscv_io_pkg::axi_id_t   memctrl_rid,
    // Control unit read data
    output logic                          mst_rvalid,
    input  wire                           mst_rready,
    output friscv_io_pkg::axi_data_t      mst_rdata,
    output friscv_io_pkg::axi_resp_t      mst_rresp,
    output friscv_io_pkg::axi_id_t        mst_rid
);

    import friscv_io_pkg::*;

    axi_addr_t io_base;
    axi_addr_t io_limit;

    // Fetcher to router, router to memory
    friscv_axi_ar_if fetch_ar_bus ();
    friscv_axi_ar_if memctrl_ar_bus ();

    friscv_cache_io_fetcher #(
        .OSTDREQ_NUM (OSTDREQ_NUM)
    ) fetcher (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .mst_arvalid (mst_arvalid),
        .mst_arready (mst_arready),
        .mst_araddr  (mst_araddr),
        .mst_arprot  (mst_arprot),
        .mst_arid    (mst_arid),
        .out_ar      (fetch_ar_bus.master)
    );

    friscv_io_range_regs range_regs (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .io_base   (io_base),
        .io_limit  (io_limit)
    );

    friscv_io_read_router router (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .req_ar         (fetch_ar_bus.slave),
        .mem_ar         (memctrl_ar_bus.master),
        .io_base        (io_base),
        .io_limit       (io_limit),
        .memctrl_rvalid (memctrl_rvalid),
        .memctrl_rready (memctrl_rready),
        .memctrl_rdata  (memctrl_rdata),
        .memctrl_rresp  (memctrl_rresp),
        .memctrl_rid    (memctrl_rid),
        .mst_rvalid     (mst_rvalid),
        .mst_rready     (mst_rready),
        .mst_rdata      (mst_rdata),
        .mst_rresp      (mst_rresp),
        .mst_rid        (mst_rid)
    );

    // Memory side bus out to plain ports
    assign memctrl_arvalid        = memctrl_ar_bus.arvalid;
    assign memctrl_araddr         = memctrl_ar_bus.araddr;
    assign memctrl_arprot         = memctrl_ar_bus.arprot;
    assign memctrl_arid           = memctrl_ar_bus.arid;
    assign memctrl_ar_bus.arready = memctrl_arready;

endmodule

`default_nettype wire

// ==== test/tb_cache_io.sv ====
//////////////////////////////////////////////////
// Directed testbench for the IO read path, with
// the testbench acting as memory controller
//////////////////////////////////////////////////

`default_nettype none

module tb_cache_io;

    timeunit 1ns;
    timeprecision 1ps;

    import friscv_io_pkg::*;

    // Cycles any single wait may take
    localparam int TIMEOUT_CYC = 200;

    logic      aclk;
    logic      rst_n;
    logic      cfg_wr;
    cfg_sel_t  cfg_sel;
    axi_addr_t cfg_wdata;
    logic      mst_arvalid;
    logic      mst_arready;
    axi_addr_t mst_araddr;
    axi_prot_t mst_arprot;
    axi_id_t   mst_arid;
    logic      memctrl_arvalid;
    logic      memctrl_arready;
    axi_addr_t memctrl_araddr;
    axi_prot_t memctrl_arprot;
    axi_id_t   memctrl_arid;
    logic      memctrl_rvalid;
    logic      memctrl_rready;
    axi_data_t memctrl_rdata;
    axi_resp_t memctrl_rresp;
    axi_id_t   memctrl_rid;
    logic      mst_rvalid;
    logic      mst_rready;
    axi_data_t mst_rdata;
    axi_resp_t mst_rresp;
    axi_id_t   mst_rid;

    // Xorshift state
    logic [31:0] rng_state = 32'd7701;

    friscv_cache_io_top #(
        .OSTDREQ_NUM (4)
    ) DUT (.*);

    // 10 ns clock
    initial aclk = 1'b0;
    always #5 aclk = ~aclk;

    //////////////////////////////////////////////////
    // Random numbers and failure reporting
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic stop_on_mismatch(input string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "Value check failed");
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: waited %0d cycles for %s without seeing it", TIMEOUT_CYC, what);
        $display(">>> FAIL");
        $fatal(1, "Wait timed out");
    endtask

    task automatic check_addr(input axi_addr_t got, input axi_addr_t exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_id(input axi_id_t got, input axi_id_t exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_prot(input axi_prot_t got, input axi_prot_t exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_data(input axi_data_t got, input axi_data_t exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_resp(input axi_resp_t got, input axi_resp_t exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_on_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    //////////////////////////////////////////////////
    // Drivers and monitors
    //////////////////////////////////////////////////

    // Offer one read address, hold it until accepted
    task automatic send_req(input axi_addr_t addr, input axi_prot_t prot, input axi_id_t id);
        int cyc;
        @(posedge aclk);
        mst_arvalid <= 1'b1;
        mst_araddr  <= addr;
        mst_arprot  <= prot;
        mst_arid    <= id;
        cyc = 0;
        do begin
            @(negedge aclk);
            cyc++;
        end while (!mst_arready && cyc < TIMEOUT_CYC);
        if (!mst_arready)
            stop_on_timeout("mst_arready on a read address");
        // Transfer edge
        @(posedge aclk);
        mst_arvalid <= 1'b0;
    endtask

    // One transfer on the memory side, payload untouched
    task automatic expect_mem_req(input axi_addr_t addr, input axi_prot_t prot,
                                  input axi_id_t id);
        int cyc;
        cyc = 0;
        do begin
            @(negedge aclk);
            cyc++;
        end while (!(memctrl_arvalid && memctrl_arready) && cyc < TIMEOUT_CYC);
        if (!(memctrl_arvalid && memctrl_arready))
            stop_on_timeout("a read address on memctrl");
        check_addr(memctrl_araddr, addr, "memctrl_araddr");
        check_prot(memctrl_arprot, prot, "memctrl_arprot");
        check_id(memctrl_arid, id, "memctrl_arid");
    endtask

    // One accepted read response; no_mem flags a decode error wait
    task automatic expect_resp(input axi_data_t data, input axi_resp_t resp,
                               input axi_id_t id, input logic no_mem);
        int cyc;
        cyc = 0;
        do begin
            @(negedge aclk);
            cyc++;
            if (no_mem)
                check_bit(memctrl_arvalid, 1'b0, "memctrl_arvalid for an out of range read");
        end while (!(mst_rvalid && mst_rready) && cyc < TIMEOUT_CYC);
        if (!(mst_rvalid && mst_rready))
            stop_on_timeout("a read response on mst_r");
        check_data(mst_rdata, data, "mst_rdata");
        check_resp(mst_rresp, resp, "mst_rresp");
        check_id(mst_rid, id, "mst_rid");
    endtask

    // Single-cycle strobe
    task automatic cfg_write(input cfg_sel_t sel, input axi_addr_t value);
        @(posedge aclk);
        cfg_wr    <= 1'b1;
        cfg_sel   <= sel;
        cfg_wdata <= value;
        @(posedge aclk);
        cfg_wr    <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        @(negedge aclk);
        check_bit(mst_arready, 1'b1, "mst_arready after reset");
        check_bit(memctrl_arvalid, 1'b0, "memctrl_arvalid after reset");
        check_bit(mst_rvalid, 1'b0, "mst_rvalid after reset");
    endtask

    // Requests in the reset window, stall count 0 or 4
    task automatic test_forward(input int num, input logic stall);
        axi_addr_t   addr_q[$];
        axi_prot_t   prot_q[$];
        axi_id_t     id_q[$];
        logic [31:0] r;
        for (int i = 0; i < num; i++) begin
            r = next_random();
            addr_q.push_back({16'h1000, r[15:0]});
            prot_q.push_back(r[18:16]);
            id_q.push_back(r[31:24]);
        end
        if (stall) begin
            @(posedge aclk);
            memctrl_arready <= 1'b0;
            for (int i = 0; i < num; i++)
                send_req(addr_q[i], prot_q[i], id_q[i]);
            // Buffer full, no fifth slot
            @(negedge aclk);
            check_bit(mst_arready, 1'b0, "mst_arready with memory stalled");
            @(posedge aclk);
            memctrl_arready <= 1'b1;
            for (int i = 0; i < num; i++)
                expect_mem_req(addr_q[i], prot_q[i], id_q[i]);
        end else begin
            fork
                for (int i = 0; i < num; i++)
                    send_req(addr_q[i], prot_q[i], id_q[i]);
                for (int i = 0; i < num; i++)
                    expect_mem_req(addr_q[i], prot_q[i], id_q[i]);
            join
        end
    endtask

    task automatic test_decerr();
        logic [31:0] r;
        r = next_random();
        send_req({16'h2000, r[15:0]}, r[18:16], r[31:24]);
        expect_resp('0, RESP_DECERR, r[31:24], 1'b1);
        // Exactly one response
        @(negedge aclk);
        check_bit(mst_rvalid, 1'b0, "mst_rvalid after the decode error");
    endtask

    task automatic test_reconfig();
        logic [31:0] r;
        cfg_write(SEL_BASE, 32'h2000_0000);
        cfg_write(SEL_LIMIT, 32'h2000_FFFF);
        r = next_random();
        send_req({16'h2000, r[15:0]}, r[18:16], r[31:24]);
        expect_mem_req({16'h2000, r[15:0]}, r[18:16], r[31:24]);
        // Old window now outside
        r = next_random();
        send_req({16'h1000, r[15:0]}, r[18:16], r[31:24]);
        expect_resp('0, RESP_DECERR, r[31:24], 1'b1);
        cfg_write(SEL_BASE, IO_BASE_RST);
        cfg_write(SEL_LIMIT, IO_LIMIT_RST);
    endtask

    task automatic test_merge();
        logic [31:0] r;
        axi_id_t     err_id;
        axi_id_t     mem_id;
        axi_data_t   mem_data;
        int          cyc;
        @(posedge aclk);
        mst_rready <= 1'b0;
        r = next_random();
        err_id = r[31:24];
        send_req({16'h3000, r[15:0]}, r[18:16], err_id);
        // Error held pending by the stalled master
        cyc = 0;
        do begin
            @(negedge aclk);
            cyc++;
        end while (!mst_rvalid && cyc < TIMEOUT_CYC);
        if (!mst_rvalid)
            stop_on_timeout("the pending decode error");
        // Memory side sees the master stall
        check_bit(memctrl_rready, 1'b0, "memctrl_rready with master stalled");
        mem_data = next_random();
        r = next_random();
        mem_id = r[7:0];
        @(posedge aclk);
        memctrl_rvalid <= 1'b1;
        memctrl_rdata  <= mem_data;
        memctrl_rresp  <= RESP_OKAY;
        memctrl_rid    <= mem_id;
        mst_rready     <= 1'b1;
        // Memory wins
        expect_resp(mem_data, RESP_OKAY, mem_id, 1'b0);
        check_bit(memctrl_rready, 1'b1, "memctrl_rready for the memory response");
        @(posedge aclk);
        memctrl_rvalid <= 1'b0;
        expect_resp('0, RESP_DECERR, err_id, 1'b0);
        @(negedge aclk);
        check_bit(mst_rvalid, 1'b0, "mst_rvalid after both responses");
    endtask

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial begin
        rst_n           = 1'b0;
        cfg_wr          = 1'b0;
        cfg_sel         = SEL_BASE;
        cfg_wdata       = '0;
        mst_arvalid     = 1'b0;
        mst_araddr      = '0;
        mst_arprot      = '0;
        mst_arid        = '0;
        memctrl_arready = 1'b1;
        memctrl_rvalid  = 1'b0;
        memctrl_rdata   = '0;
        memctrl_rresp   = RESP_OKAY;
        memctrl_rid     = '0;
        mst_rready      = 1'b1;
        repeat (16) @(posedge aclk);
        rst_n <= 1'b1;
        test_reset();
        test_forward(8, 1'b0);
        test_forward(4, 1'b1);
        test_decerr();
        test_reconfig();
        test_merge();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/friscv_io_pkg.sv
design/friscv_axi_ar_if.sv
design/friscv_scfifo.sv
design/friscv_cache_io_fetcher.sv
design/friscv_io_range_regs.sv
design/friscv_io_read_router.sv
design/friscv_cache_io_top.sv
test/tb_cache_io.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the IO read path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_cache_io -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
    exit 0
fi
exit 1
